/* lc4_pkg.sv */
package lc4_pkg;

    localparam int WORD_W = 16;
    localparam int REG_SEL_W = 3;
    localparam int NZP_W = 3;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    typedef logic [NZP_W-1:0]     nzp_t;

    localparam nzp_t NZP_N = 3'b100;
    localparam nzp_t NZP_Z = 3'b010;
    localparam nzp_t NZP_P = 3'b001;

    localparam word_t DEFAULT_RESET_PC = 16'h8200;

    // instruction field positions
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 12;
    localparam int RD_MSB = 11;
    localparam int RD_LSB = 9;
    localparam int RS_MSB = 8;
    localparam int RS_LSB = 6;
    localparam int RT_MSB = 2;
    localparam int RT_LSB = 0;
    localparam int SUBOP_MSB = 5;
    localparam int SUBOP_LSB = 3;
    localparam int IMM_FLAG_BIT = 5;
    localparam int IMM5_W = 5;
    localparam int IMM6_W = 6;
    localparam int IMM9_W = 9;
    localparam int IMM11_W = 11;

    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001,
        OP_JMP   = 4'b1100
    } opcode_t;

    // sub-op codes of the register forms
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;
    localparam logic [2:0] SUB_AND = 3'b000;
    localparam logic [2:0] SUB_OR  = 3'b010;
    localparam logic [2:0] SUB_XOR = 3'b011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_IMM,
        ALU_ZERO
    } alu_op_t;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_read;
        logic     rt_read;
        logic     rd_write;
        logic     nzp_write;
        logic     load;
        logic     store;
        logic     branch;
        logic     jump;
        logic     jump_reg;
        alu_op_t  alu_op;
        word_t    imm;
        word_t    insn;
    } decoded_t;

    function automatic nzp_t nzp_of(word_t value);
        if (value == '0) begin
            return NZP_Z;
        end
        return value[WORD_W-1] ? NZP_N : NZP_P;
    endfunction

endpackage

/* lc4_stage_if.sv */
// decoded instruction and its operands, decode to execute
interface dx_if;
    logic               valid;
    lc4_pkg::word_t     pc;
    lc4_pkg::decoded_t  decoded;
    lc4_pkg::word_t     rs_data;
    lc4_pkg::word_t     rt_data;

    modport dec (output valid, pc, decoded, rs_data, rt_data);
    modport exe (input valid, pc, decoded, rs_data, rt_data);
endinterface

// memory and writeback stage results, fed back for bypass and register write
interface wb_if;
    logic               m_valid;
    lc4_pkg::reg_sel_t  m_rd;
    logic               m_we;
    lc4_pkg::word_t     m_value;
    logic               w_valid;
    lc4_pkg::reg_sel_t  w_rd;
    logic               w_we;
    lc4_pkg::word_t     w_value;

    modport res (
        output m_valid, m_rd, m_we, m_value,
        output w_valid, w_rd, w_we, w_value
    );
    modport exe (
        input m_valid, m_rd, m_we, m_value,
        input w_valid, w_rd, w_we, w_value
    );
    modport dec (input w_valid, w_rd, w_we, w_value);
endinterface

/* lc4_regfile.sv */
module lc4_regfile (
    input  logic               gwe,
    input  logic               i_arst_n,
    input  lc4_pkg::reg_sel_t  i_rs,
    input  lc4_pkg::reg_sel_t  i_rt,
    output lc4_pkg::word_t     o_rs_data,
    output lc4_pkg::word_t     o_rt_data,
    input  lc4_pkg::reg_sel_t  i_rd,
    input  logic               i_we,
    input  lc4_pkg::word_t     i_wdata
);

    lc4_pkg::word_t regs [2**lc4_pkg::REG_SEL_W];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            foreach (regs[i]) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write-through so decode sees the value written back this cycle
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

/* lc4_decode.sv */
module lc4_decode #(
    parameter lc4_pkg::word_t RESET_PC = lc4_pkg::DEFAULT_RESET_PC
) (
    input  logic           gwe,
    input  logic           i_arst_n,
    output lc4_pkg::word_t o_pc,
    input  lc4_pkg::word_t i_insn,
    input  logic           i_redirect,
    input  lc4_pkg::word_t i_redirect_pc,
    output logic           o_stall,
    dx_if.dec              dx,
    wb_if.dec              wb
);

    lc4_pkg::word_t    f_pc;
    logic              d_valid;
    lc4_pkg::word_t    d_insn;
    lc4_pkg::word_t    d_pc;
    lc4_pkg::decoded_t dec;
    lc4_pkg::opcode_t  opcode;
    logic [2:0]        subop;
    logic              imm_flag;
    lc4_pkg::word_t    imm5;
    lc4_pkg::word_t    imm6;
    lc4_pkg::word_t    imm9;
    lc4_pkg::word_t    imm11;
    lc4_pkg::word_t    rs_data;
    lc4_pkg::word_t    rt_data;
    logic              stall;
    // shadow of the instruction now in execute
    logic              x_valid_q;
    logic              x_load_q;
    lc4_pkg::reg_sel_t x_rd_q;

    assign o_pc = f_pc;
    assign o_stall = stall;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            f_pc <= RESET_PC;
            d_valid <= 1'b0;
        end else if (i_redirect) begin
            f_pc <= i_redirect_pc;
            d_valid <= 1'b0;
        end else if (!stall) begin
            f_pc <= f_pc + 16'd1;
            d_valid <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (!stall) begin
            d_insn <= i_insn;
            d_pc <= f_pc;
        end
    end

    assign opcode = lc4_pkg::opcode_t'(d_insn[lc4_pkg::OPC_MSB:lc4_pkg::OPC_LSB]);
    assign subop = d_insn[lc4_pkg::SUBOP_MSB:lc4_pkg::SUBOP_LSB];
    assign imm_flag = d_insn[lc4_pkg::IMM_FLAG_BIT];
    assign imm5 = lc4_pkg::word_t'($signed(d_insn[lc4_pkg::IMM5_W-1:0]));
    assign imm6 = lc4_pkg::word_t'($signed(d_insn[lc4_pkg::IMM6_W-1:0]));
    assign imm9 = lc4_pkg::word_t'($signed(d_insn[lc4_pkg::IMM9_W-1:0]));
    assign imm11 = lc4_pkg::word_t'($signed(d_insn[lc4_pkg::IMM11_W-1:0]));

    always_comb begin
        dec = '0;
        dec.insn = d_insn;
        dec.rs = d_insn[lc4_pkg::RS_MSB:lc4_pkg::RS_LSB];
        dec.rt = d_insn[lc4_pkg::RT_MSB:lc4_pkg::RT_LSB];
        dec.rd = d_insn[lc4_pkg::RD_MSB:lc4_pkg::RD_LSB];
        dec.alu_op = lc4_pkg::ALU_ZERO;
        case (opcode)
            lc4_pkg::OP_BR: begin
                dec.branch = 1'b1;
                dec.imm = imm9;
            end
            lc4_pkg::OP_ARITH: begin
                if (imm_flag || subop == lc4_pkg::SUB_ADD) begin
                    dec.alu_op = lc4_pkg::ALU_ADD;
                end else if (subop == lc4_pkg::SUB_SUB) begin
                    dec.alu_op = lc4_pkg::ALU_SUB;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                if (imm_flag || subop == lc4_pkg::SUB_AND) begin
                    dec.alu_op = lc4_pkg::ALU_AND;
                end else if (subop == lc4_pkg::SUB_OR) begin
                    dec.alu_op = lc4_pkg::ALU_OR;
                end else if (subop == lc4_pkg::SUB_XOR) begin
                    dec.alu_op = lc4_pkg::ALU_XOR;
                end
            end
            lc4_pkg::OP_LDR: begin
                dec.rs_read = 1'b1;
                dec.rd_write = 1'b1;
                dec.nzp_write = 1'b1;
                dec.load = 1'b1;
                dec.imm = imm6;
            end
            lc4_pkg::OP_STR: begin
                // store data register sits in the rd field
                dec.rt = d_insn[lc4_pkg::RD_MSB:lc4_pkg::RD_LSB];
                dec.rs_read = 1'b1;
                dec.rt_read = 1'b1;
                dec.store = 1'b1;
                dec.imm = imm6;
            end
            lc4_pkg::OP_CONST: begin
                dec.rd_write = 1'b1;
                dec.nzp_write = 1'b1;
                dec.alu_op = lc4_pkg::ALU_IMM;
                dec.imm = imm9;
            end
            lc4_pkg::OP_JMP: begin
                dec.jump = 1'b1;
                dec.jump_reg = !d_insn[lc4_pkg::RD_MSB];
                dec.rs_read = !d_insn[lc4_pkg::RD_MSB];
                dec.imm = imm11;
            end
            default: begin
            end
        endcase
        // kept ALU forms; unsupported sub-ops stay no-ops
        if ((opcode == lc4_pkg::OP_ARITH || opcode == lc4_pkg::OP_LOGIC) &&
            dec.alu_op != lc4_pkg::ALU_ZERO) begin
            dec.rs_read = 1'b1;
            dec.rt_read = !imm_flag;
            dec.rd_write = 1'b1;
            dec.nzp_write = 1'b1;
            dec.imm = imm5;
        end
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs      (dec.rs),
        .i_rt      (dec.rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_rd      (wb.w_rd),
        .i_we      (wb.w_valid && wb.w_we),
        .i_wdata   (wb.w_value)
    );

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_valid_q <= 1'b0;
            x_load_q <= 1'b0;
        end else begin
            x_valid_q <= dx.valid;
            x_load_q <= dx.decoded.load;
        end
    end

    always_ff @(posedge gwe) begin
        x_rd_q <= dx.decoded.rd;
    end

    // load-use, and any branch behind a load since its NZP comes a stage late
    assign stall = d_valid && x_valid_q && x_load_q &&
                   ((dec.rs_read && dec.rs == x_rd_q) ||
                    (dec.rt_read && dec.rt == x_rd_q) ||
                    dec.branch);

    assign dx.valid = d_valid && !stall && !i_redirect;
    assign dx.pc = d_pc;
    assign dx.decoded = dec;
    assign dx.rs_data = rs_data;
    assign dx.rt_data = rt_data;

    // a load in execute never redirects, so the two PC updates cannot collide
    a_stall_redirect: assert property (
        @(posedge gwe) disable iff (!i_arst_n) !(stall && i_redirect)
    );

endmodule

/* lc4_execute.sv */
module lc4_execute (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  logic              i_stall,
    dx_if.exe                 dx,
    wb_if.exe                 wb,
    output logic              o_redirect,
    output lc4_pkg::word_t    o_redirect_pc,
    output logic              o_x_valid,
    output lc4_pkg::word_t    o_x_pc,
    output lc4_pkg::decoded_t o_x_decoded,
    output lc4_pkg::word_t    o_x_result,
    output lc4_pkg::word_t    o_x_store_data
);

    logic              x_valid;
    lc4_pkg::word_t    x_pc;
    lc4_pkg::decoded_t x_dec;
    lc4_pkg::word_t    x_rs_q;
    lc4_pkg::word_t    x_rt_q;
    lc4_pkg::word_t    rs_val;
    lc4_pkg::word_t    rt_val;
    lc4_pkg::word_t    alu_b;
    lc4_pkg::word_t    alu_y;
    logic              m_load_q;
    lc4_pkg::nzp_t     nzp_q;

    function automatic lc4_pkg::word_t bypass(
        lc4_pkg::reg_sel_t sel,
        lc4_pkg::word_t    reg_value,
        logic              m_hit_en,
        lc4_pkg::reg_sel_t m_rd,
        lc4_pkg::word_t    m_value,
        logic              w_hit_en,
        lc4_pkg::reg_sel_t w_rd,
        lc4_pkg::word_t    w_value
    );
        if (m_hit_en && m_rd == sel) begin
            return m_value;
        end
        if (w_hit_en && w_rd == sel) begin
            return w_value;
        end
        return reg_value;
    endfunction

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= dx.valid;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc <= dx.pc;
        x_dec <= dx.decoded;
        x_rs_q <= dx.rs_data;
        x_rt_q <= dx.rt_data;
    end

    // MX ahead of WX ahead of the value read in decode
    always_comb begin
        rs_val = bypass(x_dec.rs, x_rs_q, wb.m_valid && wb.m_we, wb.m_rd, wb.m_value,
                        wb.w_valid && wb.w_we, wb.w_rd, wb.w_value);
        rt_val = bypass(x_dec.rt, x_rt_q, wb.m_valid && wb.m_we, wb.m_rd, wb.m_value,
                        wb.w_valid && wb.w_we, wb.w_rd, wb.w_value);
    end

    assign alu_b = x_dec.rt_read ? rt_val : x_dec.imm;

    always_comb begin
        case (x_dec.alu_op)
            lc4_pkg::ALU_ADD: alu_y = rs_val + alu_b;
            lc4_pkg::ALU_SUB: alu_y = rs_val - alu_b;
            lc4_pkg::ALU_AND: alu_y = rs_val & alu_b;
            lc4_pkg::ALU_OR:  alu_y = rs_val | alu_b;
            lc4_pkg::ALU_XOR: alu_y = rs_val ^ alu_b;
            lc4_pkg::ALU_IMM: alu_y = x_dec.imm;
            default:          alu_y = '0;
        endcase
    end

    // loads and stores carry their address as the result
    assign o_x_result = (x_dec.load || x_dec.store) ? rs_val + x_dec.imm : alu_y;
    assign o_x_store_data = rt_val;
    assign o_x_valid = x_valid;
    assign o_x_pc = x_pc;
    assign o_x_decoded = x_dec;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_load_q <= 1'b0;
            nzp_q <= '0;
        end else begin
            m_load_q <= x_valid && x_dec.load;
            if (x_valid && x_dec.nzp_write && !x_dec.load) begin
                nzp_q <= lc4_pkg::nzp_of(o_x_result);
            end else if (m_load_q) begin
                nzp_q <= lc4_pkg::nzp_of(wb.m_value);
            end
        end
    end

    assign o_redirect = x_valid &&
                        ((x_dec.branch &&
                          |(x_dec.insn[lc4_pkg::RD_MSB:lc4_pkg::RD_LSB] & nzp_q)) ||
                         x_dec.jump);
    assign o_redirect_pc = x_dec.jump_reg ? rs_val : x_pc + 16'd1 + x_dec.imm;

    // the slot behind a redirect is always flushed
    a_redirect_flush: assert property (
        @(posedge gwe) disable iff (!i_arst_n) o_redirect |=> !x_valid
    );

    // a load-use stall hands execute a bubble
    a_stall_bubble: assert property (
        @(posedge gwe) disable iff (!i_arst_n) i_stall |=> !x_valid
    );

endmodule

/* lc4_result.sv */
module lc4_result (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  logic              i_x_valid,
    input  lc4_pkg::word_t    i_x_pc,
    input  lc4_pkg::decoded_t i_x_decoded,
    input  lc4_pkg::word_t    i_x_result,
    input  lc4_pkg::word_t    i_x_store_data,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_wdata,
    input  lc4_pkg::word_t    i_dmem_data,
    wb_if.res                 wb,
    output logic              o_rf_we,
    output lc4_pkg::reg_sel_t o_rf_wsel,
    output lc4_pkg::word_t    o_rf_wdata
);

    logic              m_valid;
    lc4_pkg::word_t    m_pc;
    lc4_pkg::decoded_t m_dec;
    lc4_pkg::word_t    m_result;
    lc4_pkg::word_t    m_store_data;
    logic              w_valid;
    lc4_pkg::word_t    w_pc;
    lc4_pkg::reg_sel_t w_rd;
    logic              w_we;
    logic              w_load;
    lc4_pkg::word_t    w_result;
    lc4_pkg::word_t    w_load_data;
    lc4_pkg::word_t    w_value;
    logic              wm_hit;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            m_valid <= i_x_valid;
            w_valid <= m_valid;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc <= i_x_pc;
        m_dec <= i_x_decoded;
        m_result <= i_x_result;
        m_store_data <= i_x_store_data;
        w_pc <= m_pc;
        w_rd <= m_dec.rd;
        w_we <= m_dec.rd_write;
        w_load <= m_dec.load;
        w_result <= m_result;
        w_load_data <= i_dmem_data;
    end

    assign w_value = w_load ? w_load_data : w_result;

    // WM bypass of the store data register
    assign wm_hit = w_valid && w_we && w_rd == m_dec.rt;

    assign o_dmem_we = m_valid && m_dec.store;
    assign o_dmem_addr = (m_valid && (m_dec.load || m_dec.store)) ? m_result : '0;
    assign o_dmem_wdata = !o_dmem_we ? '0 : (wm_hit ? w_value : m_store_data);

    // loaded data goes back already in memory, for bypass and the load NZP
    assign wb.m_valid = m_valid;
    assign wb.m_rd = m_dec.rd;
    assign wb.m_we = m_dec.rd_write;
    assign wb.m_value = m_dec.load ? i_dmem_data : m_result;
    assign wb.w_valid = w_valid;
    assign wb.w_rd = w_rd;
    assign wb.w_we = w_we;
    assign wb.w_value = w_value;

    assign o_rf_we = w_valid && w_we;
    assign o_rf_wsel = w_rd;
    assign o_rf_wdata = w_value;

    a_no_store_on_load: assert property (
        @(posedge gwe) disable iff (!i_arst_n) !(o_dmem_we && m_valid && m_dec.load)
    );

    // a stall or flush never lets one instruction reach two stages at once
    a_no_duplicate: assert property (
        @(posedge gwe) disable iff (!i_arst_n) (m_valid && w_valid) |-> m_pc != w_pc
    );

endmodule

/* lc4_core.sv */
module lc4_core #(
    parameter lc4_pkg::word_t RESET_PC = lc4_pkg::DEFAULT_RESET_PC
) (
    input  logic              gwe,
    input  logic              i_arst_n,
    output lc4_pkg::word_t    o_pc,
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_wdata,
    input  lc4_pkg::word_t    i_dmem_data,
    output logic              o_rf_we,
    output lc4_pkg::reg_sel_t o_rf_wsel,
    output lc4_pkg::word_t    o_rf_wdata
);

    logic              redirect;
    lc4_pkg::word_t    redirect_pc;
    logic              stall;
    logic              x_valid;
    lc4_pkg::word_t    x_pc;
    lc4_pkg::decoded_t x_decoded;
    lc4_pkg::word_t    x_result;
    lc4_pkg::word_t    x_store_data;

    dx_if u_dx ();
    wb_if u_wb ();

    lc4_decode #(
        .RESET_PC (RESET_PC)
    ) u_decode (
        .gwe           (gwe),
        .i_arst_n      (i_arst_n),
        .o_pc          (o_pc),
        .i_insn        (i_insn),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_stall       (stall),
        .dx            (u_dx),
        .wb            (u_wb)
    );

    lc4_execute u_execute (
        .gwe            (gwe),
        .i_arst_n       (i_arst_n),
        .i_stall        (stall),
        .dx             (u_dx),
        .wb             (u_wb),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_x_valid      (x_valid),
        .o_x_pc         (x_pc),
        .o_x_decoded    (x_decoded),
        .o_x_result     (x_result),
        .o_x_store_data (x_store_data)
    );

    lc4_result u_result (
        .gwe            (gwe),
        .i_arst_n       (i_arst_n),
        .i_x_valid      (x_valid),
        .i_x_pc         (x_pc),
        .i_x_decoded    (x_decoded),
        .i_x_result     (x_result),
        .i_x_store_data (x_store_data),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_we      (o_dmem_we),
        .o_dmem_wdata   (o_dmem_wdata),
        .i_dmem_data    (i_dmem_data),
        .wb             (u_wb),
        .o_rf_we        (o_rf_we),
        .o_rf_wsel      (o_rf_wsel),
        .o_rf_wdata     (o_rf_wdata)
    );

endmodule

/* tb_lc4_core.sv */
module tb_lc4_core;

    localparam lc4_pkg::word_t RESET_PC = 16'h0040;
    localparam int WATCHDOG_PER_INSN = 60;
    localparam int IMEM_WINDOW = 64;
    localparam int DMEM_WINDOW = 512;
    localparam int BR_DATA_ADDR = 12;
    localparam logic [3:0] OPC_ARITH = 4'b0001;
    localparam logic [3:0] OPC_LOGIC = 4'b0101;

    logic              gwe;
    logic              i_arst_n;
    lc4_pkg::word_t    o_pc;
    lc4_pkg::word_t    i_insn;
    lc4_pkg::word_t    o_dmem_addr;
    logic              o_dmem_we;
    lc4_pkg::word_t    o_dmem_wdata;
    lc4_pkg::word_t    i_dmem_data;
    logic              o_rf_we;
    lc4_pkg::reg_sel_t o_rf_wsel;
    lc4_pkg::word_t    o_rf_wdata;

    lc4_pkg::word_t imem [0:65535];
    lc4_pkg::word_t dmem [0:65535];

    // observed and expected register writes and stores, in program order
    logic [2:0]     rec_rd [$];
    lc4_pkg::word_t rec_val [$];
    lc4_pkg::word_t rec_st_addr [$];
    lc4_pkg::word_t rec_st_data [$];
    logic [2:0]     exp_rd [$];
    lc4_pkg::word_t exp_val [$];
    lc4_pkg::word_t exp_st_addr [$];
    lc4_pkg::word_t exp_st_data [$];

    int prog_len;
    int total_insns;
    int errors;
    int cycles;

    lc4_core #(
        .RESET_PC (RESET_PC)
    ) u_lc4_core (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .o_pc         (o_pc),
        .i_insn       (i_insn),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_data  (i_dmem_data),
        .o_rf_we      (o_rf_we),
        .o_rf_wsel    (o_rf_wsel),
        .o_rf_wdata   (o_rf_wdata)
    );

    always #2 gwe = ~gwe;

    // both memories answer from the address of the current cycle
    always @(negedge gwe) begin
        if (o_dmem_we) begin
            dmem[o_dmem_addr] = o_dmem_wdata;
        end
        i_insn <= imem[o_pc];
        i_dmem_data <= dmem[o_dmem_addr];
    end

    always @(negedge gwe) begin
        if (i_arst_n && o_rf_we) begin
            rec_rd.push_back(o_rf_wsel);
            rec_val.push_back(o_rf_wdata);
        end
        if (i_arst_n && o_dmem_we) begin
            rec_st_addr.push_back(o_dmem_addr);
            rec_st_data.push_back(o_dmem_wdata);
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= WATCHDOG_PER_INSN * (total_insns + 1)) begin
            @(posedge gwe);
            cycles++;
        end
        $display("watchdog expired after %0d cycles, the pipeline never finished", cycles);
        $display("Some tests failed");
        $fatal(1, "run stopped by the watchdog");
    end

    function automatic lc4_pkg::word_t sext5(input logic [4:0] raw);
        return {{11{raw[4]}}, raw};
    endfunction

    function automatic lc4_pkg::word_t sext9(input logic [8:0] raw);
        return {{7{raw[8]}}, raw};
    endfunction

    function automatic logic [2:0] cond_of(input lc4_pkg::word_t value);
        if (value == 16'd0) begin
            return 3'b010;
        end
        return value[15] ? 3'b100 : 3'b001;
    endfunction

    // depends on every address bit so aliasing shows up as wrong data
    function automatic lc4_pkg::word_t data_pattern(input lc4_pkg::word_t addr);
        return (addr * 16'h9e37) ^ {addr[7:0], addr[15:8]} ^ 16'h5a5a;
    endfunction

    function automatic lc4_pkg::word_t const_insn(input logic [2:0] rd, input logic [8:0] imm);
        return {4'b1001, rd, imm};
    endfunction

    function automatic lc4_pkg::word_t rr_insn(input logic [3:0] opc, input logic [2:0] rd,
                                               input logic [2:0] rs, input logic [2:0] sub,
                                               input logic [2:0] rt);
        return {opc, rd, rs, sub, rt};
    endfunction

    function automatic lc4_pkg::word_t ri_insn(input logic [3:0] opc, input logic [2:0] rd,
                                               input logic [2:0] rs, input logic [4:0] imm);
        return {opc, rd, rs, 1'b1, imm};
    endfunction

    function automatic lc4_pkg::word_t ldr_insn(input logic [2:0] rd, input logic [2:0] rs,
                                                input logic [5:0] imm);
        return {4'b0110, rd, rs, imm};
    endfunction

    function automatic lc4_pkg::word_t str_insn(input logic [2:0] rt, input logic [2:0] rs,
                                                input logic [5:0] imm);
        return {4'b0111, rt, rs, imm};
    endfunction

    function automatic lc4_pkg::word_t br_insn(input logic [2:0] nzp, input logic [8:0] imm);
        return {4'b0000, nzp, imm};
    endfunction

    function automatic lc4_pkg::word_t jmp_insn(input logic [10:0] imm);
        return {4'b1100, 1'b1, imm};
    endfunction

    function automatic lc4_pkg::word_t jmpr_insn(input logic [2:0] rs);
        return {4'b1100, 3'b000, rs, 6'b000000};
    endfunction

    task automatic check_value(input string name, input lc4_pkg::word_t got,
                               input lc4_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic start_program();
        prog_len = 0;
        exp_rd.delete();
        exp_val.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        for (int i = 0; i < IMEM_WINDOW; i++) begin
            imem[RESET_PC + i] = '0;
        end
        for (int a = 0; a < DMEM_WINDOW; a++) begin
            dmem[a] = data_pattern(16'(a));
        end
    endtask

    task automatic emit(input lc4_pkg::word_t insn);
        imem[RESET_PC + prog_len] = insn;
        prog_len++;
        total_insns++;
    endtask

    task automatic expect_write(input logic [2:0] rd, input lc4_pkg::word_t value);
        exp_rd.push_back(rd);
        exp_val.push_back(value);
    endtask

    task automatic expect_store(input lc4_pkg::word_t addr, input lc4_pkg::word_t data);
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(data);
    endtask

    task automatic reset_dut();
        @(negedge gwe);
        i_arst_n <= 1'b0;
        rec_rd.delete();
        rec_val.delete();
        rec_st_addr.delete();
        rec_st_data.delete();
        repeat (3) @(negedge gwe);
        i_arst_n <= 1'b1;
    endtask

    task automatic wait_pc(input lc4_pkg::word_t target);
        while (o_pc !== target) begin
            @(negedge gwe);
        end
    endtask

    task automatic compare_results();
        check_value("write count", 16'(rec_rd.size()), 16'(exp_rd.size()));
        for (int i = 0; i < exp_rd.size(); i++) begin
            check_value("o_rf_wsel", 16'(rec_rd[i]), 16'(exp_rd[i]));
            check_value("o_rf_wdata", rec_val[i], exp_val[i]);
        end
        check_value("store count", 16'(rec_st_addr.size()), 16'(exp_st_addr.size()));
        for (int i = 0; i < exp_st_addr.size(); i++) begin
            check_value("o_dmem_addr", rec_st_addr[i], exp_st_addr[i]);
            check_value("o_dmem_wdata", rec_st_data[i], exp_st_data[i]);
        end
    endtask

    // a drained pipeline has fetched a few NOPs past the last instruction
    task automatic run_program();
        reset_dut();
        wait_pc(RESET_PC + 16'(prog_len) + 16'd6);
        compare_results();
    endtask

    task automatic reset_test();
        start_program();
        reset_dut();
        check_value("o_pc", o_pc, RESET_PC);
        check_value("o_rf_we", 16'(o_rf_we), 16'd0);
        check_value("o_dmem_we", 16'(o_dmem_we), 16'd0);
        @(negedge gwe);
        check_value("o_pc", o_pc, RESET_PC + 16'd1);
        check_value("o_rf_we", 16'(o_rf_we), 16'd0);
    endtask

    task automatic alu_chain_test();
        logic [8:0]     a;
        logic [8:0]     b;
        logic [4:0]     c;
        logic [4:0]     d;
        lc4_pkg::word_t v [8];
        a = 9'($urandom);
        b = 9'($urandom);
        c = 5'($urandom);
        d = 5'($urandom);
        start_program();
        v[1] = sext9(a);
        v[2] = sext9(b);
        v[3] = v[1] + v[2];
        v[4] = v[3] - v[1];
        v[5] = v[4] & v[3];
        v[6] = v[5] | v[2];
        v[7] = v[6] ^ v[5];
        emit(const_insn(3'd1, a));
        emit(const_insn(3'd2, b));
        emit(rr_insn(OPC_ARITH, 3'd3, 3'd1, 3'b000, 3'd2));
        emit(rr_insn(OPC_ARITH, 3'd4, 3'd3, 3'b010, 3'd1));
        emit(rr_insn(OPC_LOGIC, 3'd5, 3'd4, 3'b000, 3'd3));
        emit(rr_insn(OPC_LOGIC, 3'd6, 3'd5, 3'b010, 3'd2));
        emit(rr_insn(OPC_LOGIC, 3'd7, 3'd6, 3'b011, 3'd5));
        for (int r = 1; r < 8; r++) begin
            expect_write(3'(r), v[r]);
        end
        emit(ri_insn(OPC_ARITH, 3'd1, 3'd7, c));
        expect_write(3'd1, v[7] + sext5(c));
        emit(ri_insn(OPC_LOGIC, 3'd2, 3'd1, d));
        expect_write(3'd2, (v[7] + sext5(c)) & sext5(d));
        run_program();
    endtask

    task automatic load_store_test();
        logic [8:0]     base;
        logic [8:0]     raw;
        lc4_pkg::word_t vb;
        lc4_pkg::word_t vv;
        lc4_pkg::word_t sum;
        lc4_pkg::word_t pat;
        base = 9'($urandom % 64) + 9'd16;
        raw = 9'($urandom);
        vb = sext9(base);
        vv = sext9(raw);
        sum = vv + vb;
        pat = data_pattern(vb + 16'd9);
        start_program();
        emit(const_insn(3'd1, base));
        emit(const_insn(3'd2, raw));
        emit(rr_insn(OPC_ARITH, 3'd3, 3'd2, 3'b000, 3'd1));
        emit(str_insn(3'd3, 3'd1, 6'd5));
        emit(ldr_insn(3'd4, 3'd1, 6'd5));
        emit(rr_insn(OPC_ARITH, 3'd5, 3'd4, 3'b000, 3'd2));
        emit(ldr_insn(3'd6, 3'd1, 6'd9));
        emit(rr_insn(OPC_ARITH, 3'd7, 3'd6, 3'b000, 3'd6));
        expect_write(3'd1, vb);
        expect_write(3'd2, vv);
        expect_write(3'd3, sum);
        expect_store(vb + 16'd5, sum);
        expect_write(3'd4, sum);
        expect_write(3'd5, sum + vv);
        expect_write(3'd6, pat);
        expect_write(3'd7, pat + pat);
        run_program();
    endtask

    task automatic branch_case(input int kind, input int cls, input logic [2:0] mask);
        logic [8:0]     raw;
        lc4_pkg::word_t v;
        logic           taken;
        case (cls)
            0: raw = {1'b1, 8'($urandom)};
            1: raw = 9'd0;
            default: raw = {1'b0, 8'($urandom) | 8'h01};
        endcase
        v = sext9(raw);
        taken = |(mask & cond_of(v));
        start_program();
        if (kind == 0) begin
            emit(const_insn(3'd1, raw));
            emit(rr_insn(OPC_ARITH, 3'd2, 3'd1, 3'b000, 3'd0));
            expect_write(3'd1, v);
        end else begin
            // the branch condition must come from the loaded word, not the CONST
            dmem[BR_DATA_ADDR] = v;
            emit(const_insn(3'd1, 9'd1));
            emit(ldr_insn(3'd2, 3'd0, 6'(BR_DATA_ADDR)));
            expect_write(3'd1, 16'd1);
        end
        expect_write(3'd2, v);
        emit(br_insn(mask, 9'd2));
        emit(const_insn(3'd3, 9'd11));
        emit(const_insn(3'd4, 9'd12));
        emit(const_insn(3'd5, 9'd13));
        if (!taken) begin
            expect_write(3'd3, 16'd11);
            expect_write(3'd4, 16'd12);
        end
        expect_write(3'd5, 16'd13);
        run_program();
    endtask

    task automatic branch_test();
        for (int kind = 0; kind < 2; kind++) begin
            for (int cls = 0; cls < 3; cls++) begin
                for (int mask = 0; mask < 8; mask++) begin
                    branch_case(kind, cls, 3'(mask));
                end
            end
        end
    endtask

    task automatic jump_test();
        start_program();
        emit(const_insn(3'd1, 9'(RESET_PC + 16'd8)));
        emit(ri_insn(OPC_ARITH, 3'd1, 3'd1, 5'd2));
        emit(jmpr_insn(3'd1));
        emit(const_insn(3'd2, 9'd11));
        emit(const_insn(3'd3, 9'd12));
        for (int i = 0; i < 5; i++) begin
            emit(16'h0000);
        end
        // JMPR lands here at offset 10
        emit(const_insn(3'd4, 9'd21));
        emit(jmp_insn(11'd3));
        emit(const_insn(3'd5, 9'd31));
        emit(const_insn(3'd6, 9'd32));
        emit(const_insn(3'd7, 9'd33));
        emit(const_insn(3'd5, 9'd41));
        emit(rr_insn(OPC_ARITH, 3'd6, 3'd4, 3'b000, 3'd5));
        expect_write(3'd1, RESET_PC + 16'd8);
        expect_write(3'd1, RESET_PC + 16'd10);
        expect_write(3'd4, 16'd21);
        expect_write(3'd5, 16'd41);
        expect_write(3'd6, 16'd62);
        run_program();
    endtask

    initial begin
        void'($urandom(32'hc5f5));
        gwe = 1'b0;
        i_arst_n = 1'b0;
        i_insn = '0;
        i_dmem_data = '0;
        errors = 0;
        total_insns = 0;
        prog_len = 0;
        for (int a = 0; a < 65536; a++) begin
            imem[a] = '0;
            dmem[a] = data_pattern(16'(a));
        end
        reset_test();
        alu_chain_test();
        load_store_test();
        branch_test();
        jump_test();
        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "%0d checks did not match", errors);
        end
    end

endmodule

/* filelist.f */
lc4_pkg.sv
lc4_stage_if.sv
lc4_regfile.sv
lc4_decode.sv
lc4_execute.sv
lc4_result.sv
lc4_core.sv
tb_lc4_core.sv

/* Bender.yml */
package:
  name: lc4_core

sources:
  - lc4_pkg.sv
  - lc4_stage_if.sv
  - lc4_regfile.sv
  - lc4_decode.sv
  - lc4_execute.sv
  - lc4_result.sv
  - lc4_core.sv
  - target: test
    files:
      - tb_lc4_core.sv
